/* include/aip_config.svh */
`ifndef AIP_CONFIG_SVH
`define AIP_CONFIG_SVH

// Bus and memory widths
`define AIP_DATA_WIDTH   32
`define AIP_CFG_WIDTH    5
`define AIP_MEMIN_AW     5
`define AIP_MEMOUT_AW    6
`define AIP_STATUS_WIDTH 8

`define AIP_IP_ID 32'h4004_8008

// Host configuration codes in DATA and PTR pairs
`define CFG_MEMIN0_DATA 5'd0
`define CFG_MEMIN0_PTR  5'd1
`define CFG_MEMIN1_DATA 5'd2
`define CFG_MEMIN1_PTR  5'd3
`define CFG_MEMOUT_DATA 5'd4
`define CFG_MEMOUT_PTR  5'd5
`define CFG_CONF_DATA   5'd6
`define CFG_CONF_PTR    5'd7

`define CFG_STATUS 5'd30
`define CFG_ID     5'd31

`endif

/* hdl/aipPkg.sv */
`include "aip_config.svh"

package aipPkg;

  typedef logic [`AIP_DATA_WIDTH-1:0]   aipData_t;
  typedef logic [`AIP_CFG_WIDTH-1:0]    aipCfg_t;
  typedef logic [`AIP_MEMIN_AW-1:0]     memInAddr_t;
  typedef logic [`AIP_MEMOUT_AW-1:0]    memOutAddr_t;
  typedef logic [`AIP_STATUS_WIDTH-1:0] statusByte_t;

  // Host read source
  typedef enum logic [1:0] {
    SEL_MEMOUT,
    SEL_STATUS,
    SEL_ID
  } readSel_t;

  // Decoded host command shared by execute and result
  typedef struct packed {
    logic        wrEnMemIn0;
    memInAddr_t  wrAddrMemIn0;
    logic        wrEnMemIn1;
    memInAddr_t  wrAddrMemIn1;
    memOutAddr_t rdAddrMemOut;
    logic        wrEnConfigReg;
    logic        setStatus;
    readSel_t    readSel;
  } aipCmd_t;

endpackage

/* hdl/aipBankRam.sv */
`timescale 1ns/1ps

module aipBankRam import aipPkg::*; #(
  parameter int ADDR_WIDTH = 5
) (
  input  logic                  clk,
  input  logic                  wrEn_i,
  input  logic [ADDR_WIDTH-1:0] wrAddr_i,
  input  aipData_t              wrData_i,
  input  logic [ADDR_WIDTH-1:0] rdAddr_i,
  output aipData_t              rdData_o
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  aipData_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
  end

  // Read port is combinational
  assign rdData_o = mem[rdAddr_i];

endmodule

/* hdl/aipCmdDecode.sv */
`timescale 1ns/1ps
`include "aip_config.svh"

module aipCmdDecode import aipPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     en_i,
  input  aipCfg_t  configAip_i,
  input  aipData_t dataInAip_i,
  input  logic     writeAip_i,
  input  logic     readAip_i,
  output aipCmd_t  cmd_o
);

  memInAddr_t  memIn0Ptr;
  memInAddr_t  memIn1Ptr;
  memOutAddr_t memOutPtr;
  readSel_t    readSel;

  always_comb begin
    case (configAip_i)
      `CFG_MEMOUT_DATA: readSel = SEL_MEMOUT;
      `CFG_STATUS:      readSel = SEL_STATUS;
      `CFG_ID:          readSel = SEL_ID;
      default:          readSel = SEL_ID; // Unused codes read back the ID
    endcase
  end

  // Data strobes ignore en_i
  assign cmd_o.wrEnMemIn0    = writeAip_i && (configAip_i == `CFG_MEMIN0_DATA);
  assign cmd_o.wrEnMemIn1    = writeAip_i && (configAip_i == `CFG_MEMIN1_DATA);
  assign cmd_o.wrEnConfigReg = writeAip_i && (configAip_i == `CFG_CONF_DATA);
  assign cmd_o.setStatus     = writeAip_i && (configAip_i == `CFG_STATUS);
  assign cmd_o.wrAddrMemIn0  = memIn0Ptr;
  assign cmd_o.wrAddrMemIn1  = memIn1Ptr;
  assign cmd_o.rdAddrMemOut  = memOutPtr;
  assign cmd_o.readSel       = readSel;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      memIn0Ptr <= '0;
      memIn1Ptr <= '0;
      memOutPtr <= '0;
    end else if (en_i) begin
      if (writeAip_i && configAip_i == `CFG_MEMIN0_PTR) begin
        memIn0Ptr <= dataInAip_i[`AIP_MEMIN_AW-1:0];
      end else if (cmd_o.wrEnMemIn0) begin
        memIn0Ptr <= memIn0Ptr + 1'b1; // Wraps at bank depth
      end

      if (writeAip_i && configAip_i == `CFG_MEMIN1_PTR) begin
        memIn1Ptr <= dataInAip_i[`AIP_MEMIN_AW-1:0];
      end else if (cmd_o.wrEnMemIn1) begin
        memIn1Ptr <= memIn1Ptr + 1'b1;
      end

      // Read pointer moves after the current word was presented
      if (writeAip_i && configAip_i == `CFG_MEMOUT_PTR) begin
        memOutPtr <= dataInAip_i[`AIP_MEMOUT_AW-1:0];
      end else if (readAip_i && configAip_i == `CFG_MEMOUT_DATA) begin
        memOutPtr <= memOutPtr + 1'b1;
      end
    end
  end

endmodule

/* hdl/aipExecute.sv */
`timescale 1ns/1ps
`include "aip_config.svh"

module aipExecute import aipPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  aipCmd_t     cmd_i,
  input  aipData_t    dataInAip_i,
  input  memInAddr_t  rdAddrMemIn0_i,
  input  memInAddr_t  rdAddrMemIn1_i,
  output aipData_t    rdDataMemIn0_o,
  output aipData_t    rdDataMemIn1_o,
  input  aipData_t    wrDataMemOut_i,
  input  memOutAddr_t wrAddrMemOut_i,
  input  logic        wrEnMemOut_i,
  output aipData_t    rdDataMemOut_o,
  output aipData_t    rdDataConfigReg_o
);

  aipData_t configReg;

  // Input banks written by the host and read by the core
  aipBankRam #(
    .ADDR_WIDTH (`AIP_MEMIN_AW)
  ) memIn0 (
    .clk      (clk),
    .wrEn_i   (cmd_i.wrEnMemIn0),
    .wrAddr_i (cmd_i.wrAddrMemIn0),
    .wrData_i (dataInAip_i),
    .rdAddr_i (rdAddrMemIn0_i),
    .rdData_o (rdDataMemIn0_o)
  );

  aipBankRam #(
    .ADDR_WIDTH (`AIP_MEMIN_AW)
  ) memIn1 (
    .clk      (clk),
    .wrEn_i   (cmd_i.wrEnMemIn1),
    .wrAddr_i (cmd_i.wrAddrMemIn1),
    .wrData_i (dataInAip_i),
    .rdAddr_i (rdAddrMemIn1_i),
    .rdData_o (rdDataMemIn1_o)
  );

  // Output bank written by the core and read by the host
  aipBankRam #(
    .ADDR_WIDTH (`AIP_MEMOUT_AW)
  ) memOut (
    .clk      (clk),
    .wrEn_i   (wrEnMemOut_i),
    .wrAddr_i (wrAddrMemOut_i),
    .wrData_i (wrDataMemOut_i),
    .rdAddr_i (cmd_i.rdAddrMemOut),
    .rdData_o (rdDataMemOut_o)
  );

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      configReg <= '0;
    end else if (cmd_i.wrEnConfigReg) begin
      configReg <= dataInAip_i;
    end
  end

  assign rdDataConfigReg_o = configReg; // Core sees it continuously

endmodule

/* hdl/aipResult.sv */
`timescale 1ns/1ps
`include "aip_config.svh"

module aipResult import aipPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  aipCmd_t  cmd_i,
  input  aipData_t dataInAip_i,
  input  aipData_t rdDataMemOut_i,
  input  logic     statusBusy_i,
  input  logic     doneIrq_i,
  output aipData_t dataOutAip_o,
  output logic     intAip_o
);

  localparam aipData_t IP_ID = `AIP_IP_ID;
  localparam int PAD_WIDTH = `AIP_DATA_WIDTH - 2 * `AIP_STATUS_WIDTH - 1;

  statusByte_t coreStatus;
  statusByte_t coreIrq;
  statusByte_t irqPending;
  statusByte_t irqPendingNext;
  statusByte_t irqClear;
  logic        intEn;
  logic        intEnNext;
  aipData_t    statusWord;

  // Only bit 0 of each core field is wired
  assign coreStatus = {{(`AIP_STATUS_WIDTH-1){1'b0}}, statusBusy_i};
  assign coreIrq    = {{(`AIP_STATUS_WIDTH-1){1'b0}}, doneIrq_i};

  always_comb begin
    irqClear  = '0;
    intEnNext = intEn;
    if (cmd_i.setStatus) begin
      irqClear  = dataInAip_i[2*`AIP_STATUS_WIDTH-1:`AIP_STATUS_WIDTH];
      intEnNext = dataInAip_i[2*`AIP_STATUS_WIDTH];
    end
    // New core flag beats a clear in the same cycle
    irqPendingNext = (irqPending & ~irqClear) | coreIrq;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      irqPending <= '0;
      intEn      <= 1'b0;
      intAip_o   <= 1'b0;
    end else begin
      irqPending <= irqPendingNext;
      intEn      <= intEnNext;
      intAip_o   <= intEnNext & (|irqPendingNext);
    end
  end

  assign statusWord = {{PAD_WIDTH{1'b0}}, intEn, irqPending, coreStatus};

  always_comb begin
    case (cmd_i.readSel)
      SEL_MEMOUT: dataOutAip_o = rdDataMemOut_i;
      SEL_STATUS: dataOutAip_o = statusWord;
      default:    dataOutAip_o = IP_ID;
    endcase
  end

endmodule

/* hdl/aipTop.sv */
`timescale 1ns/1ps
`include "aip_config.svh"

module aipTop import aipPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        en_i,
  input  aipCfg_t     configAip_i,
  input  aipData_t    dataInAip_i,
  input  logic        writeAip_i,
  input  logic        readAip_i,
  input  logic        startAip_i,
  output aipData_t    dataOutAip_o,
  output logic        intAip_o,
  input  memInAddr_t  rdAddrMemIn0_i,
  input  memInAddr_t  rdAddrMemIn1_i,
  output aipData_t    rdDataMemIn0_o,
  output aipData_t    rdDataMemIn1_o,
  input  aipData_t    wrDataMemOut_i,
  input  memOutAddr_t wrAddrMemOut_i,
  input  logic        wrEnMemOut_i,
  output aipData_t    rdDataConfigReg_o,
  input  logic        statusBusy_i,
  input  logic        doneIrq_i,
  output logic        startCore_o
);

  aipCmd_t  cmd;
  aipData_t rdDataMemOut;

  aipCmdDecode i_decode (
    .clk         (clk),
    .rst         (rst),
    .en_i        (en_i),
    .configAip_i (configAip_i),
    .dataInAip_i (dataInAip_i),
    .writeAip_i  (writeAip_i),
    .readAip_i   (readAip_i),
    .cmd_o       (cmd)
  );

  aipExecute i_execute (
    .clk               (clk),
    .rst               (rst),
    .cmd_i             (cmd),
    .dataInAip_i       (dataInAip_i),
    .rdAddrMemIn0_i    (rdAddrMemIn0_i),
    .rdAddrMemIn1_i    (rdAddrMemIn1_i),
    .rdDataMemIn0_o    (rdDataMemIn0_o),
    .rdDataMemIn1_o    (rdDataMemIn1_o),
    .wrDataMemOut_i    (wrDataMemOut_i),
    .wrAddrMemOut_i    (wrAddrMemOut_i),
    .wrEnMemOut_i      (wrEnMemOut_i),
    .rdDataMemOut_o    (rdDataMemOut),
    .rdDataConfigReg_o (rdDataConfigReg_o)
  );

  aipResult i_result (
    .clk            (clk),
    .rst            (rst),
    .cmd_i          (cmd),
    .dataInAip_i    (dataInAip_i),
    .rdDataMemOut_i (rdDataMemOut),
    .statusBusy_i   (statusBusy_i),
    .doneIrq_i      (doneIrq_i),
    .dataOutAip_o   (dataOutAip_o),
    .intAip_o       (intAip_o)
  );

  assign startCore_o = startAip_i; // Straight to the core

endmodule

/* verification/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial begin
    rst = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst = 1'b1;
  end

endmodule

/* verification/aipChecker.sv */
`timescale 1ns/1ps
`include "aip_config.svh"

module aipChecker import aipPkg::*; (
  input  logic     clk,
  input  int       chkSel_i,
  input  int       testId_i,
  input  aipData_t expVal_i,
  input  aipData_t dataOut_i,
  input  aipData_t memIn0_i,
  input  aipData_t memIn1_i,
  input  aipData_t configReg_i,
  input  logic     int_i,
  input  logic     start_i,
  output int       errCount_o,
  output int       checkCount_o
);

  aipData_t actual;
  string    name;

  initial begin
    errCount_o   = 0;
    checkCount_o = 0;
  end

  // Sample late in the cycle after the 1 ns drive
  always @(posedge clk) begin
    #7;
    if (chkSel_i != 0) begin
      case (chkSel_i)
        1: begin
          actual = dataOut_i;
          name   = "dataOutAip_o";
        end
        2: begin
          actual = memIn0_i;
          name   = "rdDataMemIn0_o";
        end
        3: begin
          actual = memIn1_i;
          name   = "rdDataMemIn1_o";
        end
        4: begin
          actual = configReg_i;
          name   = "rdDataConfigReg_o";
        end
        5: begin
          actual = {31'b0, int_i};
          name   = "intAip_o";
        end
        default: begin
          actual = {31'b0, start_i};
          name   = "startCore_o";
        end
      endcase
      checkCount_o = checkCount_o + 1;
      if (actual !== expVal_i) begin
        errCount_o = errCount_o + 1;
        $display("[ERROR] %0d ns test %0d %s expected %h actual %h",
                 $time, testId_i, name, expVal_i, actual);
      end else begin
        $display("test %0d: %s = %h ok", testId_i, name, actual);
      end
    end
  end

endmodule

/* verification/aipTb.sv */
`timescale 1ns/1ps
`include "aip_config.svh"

module aipTb import aipPkg::*; ;

  localparam int OP_IDLE = 0, OP_HWRITE = 1, OP_HREAD = 2, OP_CWRITE = 3;
  localparam int OP_CREAD = 4, OP_STAT = 5, OP_DONE = 6, OP_START = 7;
  localparam int CHK_NONE = 0, CHK_DOUT = 1, CHK_MEM0 = 2, CHK_MEM1 = 3;
  localparam int CHK_CONF = 4, CHK_INT = 5, CHK_START = 6;

  typedef struct packed {
    int       op;
    aipCfg_t  code;
    logic     en;
    aipData_t data;
    int       addr;
    int       chk;
    aipData_t exp;
  } entry_t;

  logic clk, rst, en, writeAip, readAip, startAip, wrEnMemOut, busy, doneIrq, intAip, startCore;
  aipCfg_t configAip;
  aipData_t dataIn, dataOut, memIn0Data, memIn1Data, wrDataMemOut, configReg, expVal;
  memInAddr_t rdAddr0, rdAddr1;
  memOutAddr_t wrAddrMemOut;
  int chkSel, testId, errCount, checkCount;
  entry_t tbl[$];
  entry_t e;
  logic built = 1'b0;

  // Reference model
  aipData_t mem0 [32], mem1 [32], memOut [64];
  bit w0 [32], w1 [32];
  int p0 = 0, p1 = 0, pOut = 0, seed = 32'h2141_5f1f;
  logic pending = 1'b0, intEn = 1'b0, busyM = 1'b0;

  tbClock i_clock (.clk(clk), .rst(rst));

  aipTop i_dut (
    .clk(clk), .rst(rst), .en_i(en), .configAip_i(configAip), .dataInAip_i(dataIn),
    .writeAip_i(writeAip), .readAip_i(readAip), .startAip_i(startAip),
    .dataOutAip_o(dataOut), .intAip_o(intAip), .rdAddrMemIn0_i(rdAddr0),
    .rdAddrMemIn1_i(rdAddr1), .rdDataMemIn0_o(memIn0Data), .rdDataMemIn1_o(memIn1Data),
    .wrDataMemOut_i(wrDataMemOut), .wrAddrMemOut_i(wrAddrMemOut), .wrEnMemOut_i(wrEnMemOut),
    .rdDataConfigReg_o(configReg), .statusBusy_i(busy), .doneIrq_i(doneIrq),
    .startCore_o(startCore)
  );

  aipChecker i_checker (
    .clk(clk), .chkSel_i(chkSel), .testId_i(testId), .expVal_i(expVal),
    .dataOut_i(dataOut), .memIn0_i(memIn0Data), .memIn1_i(memIn1Data),
    .configReg_i(configReg), .int_i(intAip), .start_i(startCore),
    .errCount_o(errCount), .checkCount_o(checkCount)
  );

  task automatic add(int op, aipCfg_t code, logic en, aipData_t data, int addr, int chk,
                     aipData_t exp);
    tbl.push_back('{op, code, en, data, addr, chk, exp});
  endtask

  function automatic aipData_t statusWord();
    return {15'b0, intEn, 7'b0, pending, 7'b0, busyM};
  endfunction

  task automatic hostWrite(aipCfg_t code, logic en, aipData_t data);
    case (code)
      `CFG_MEMIN0_DATA: begin
        mem0[p0] = data;
        w0[p0] = 1;
        if (en) p0 = (p0 + 1) % 32;
      end
      `CFG_MEMIN1_DATA: begin
        mem1[p1] = data;
        w1[p1] = 1;
        if (en) p1 = (p1 + 1) % 32;
      end
      `CFG_MEMIN0_PTR:  if (en) p0 = data[4:0];
      `CFG_MEMIN1_PTR:  if (en) p1 = data[4:0];
      `CFG_MEMOUT_PTR:  if (en) pOut = data[5:0];
      `CFG_STATUS: begin
        intEn = data[16];
        pending = pending & ~data[8];
      end
      default: ;
    endcase
    add(OP_HWRITE, code, en, data, 0, CHK_NONE, '0);
  endtask

  task automatic buildTable();
    add(OP_IDLE, `CFG_ID, 1, 0, 0, CHK_CONF, '0);
    add(OP_HREAD, `CFG_ID, 1, 0, 0, CHK_DOUT, `AIP_IP_ID);
    add(OP_HREAD, 5'd9, 1, 0, 0, CHK_DOUT, `AIP_IP_ID);
    hostWrite(`CFG_MEMIN1_DATA, 1, $random(seed)); // Pointer starts at 0
    add(OP_CREAD, `CFG_ID, 1, 0, 0, CHK_MEM1, mem1[0]);
    hostWrite(`CFG_MEMIN0_PTR, 1, 29);
    repeat (5) hostWrite(`CFG_MEMIN0_DATA, 1, $random(seed));
    hostWrite(`CFG_MEMIN1_PTR, 1, 29);
    repeat (4) hostWrite(`CFG_MEMIN1_DATA, 1, $random(seed));
    hostWrite(`CFG_MEMIN0_PTR, 0, 10); // Ignored with en_i low
    repeat (3) hostWrite(`CFG_MEMIN0_DATA, 0, $random(seed));
    for (int a = 0; a < 32; a++) begin
      if (w0[a]) add(OP_CREAD, `CFG_ID, 1, 0, a, CHK_MEM0, mem0[a]);
      if (w1[a]) add(OP_CREAD, `CFG_ID, 1, 0, a, CHK_MEM1, mem1[a]);
    end
    for (int a = 0; a < 64; a++) begin
      memOut[a] = $random(seed);
      add(OP_CWRITE, `CFG_ID, 1, memOut[a], a, CHK_NONE, '0);
    end
    hostWrite(`CFG_MEMOUT_PTR, 1, 60);
    repeat (8) begin
      add(OP_HREAD, `CFG_MEMOUT_DATA, 1, 0, 0, CHK_DOUT, memOut[pOut]);
      pOut = (pOut + 1) % 64;
    end
    hostWrite(`CFG_CONF_DATA, 1, 32'h1234_5678);
    add(OP_IDLE, `CFG_ID, 1, 0, 0, CHK_CONF, 32'h1234_5678);
    hostWrite(`CFG_CONF_PTR, 1, 0);
    hostWrite(`CFG_CONF_DATA, 1, 32'hcafe_0042);
    add(OP_IDLE, `CFG_ID, 1, 0, 0, CHK_CONF, 32'hcafe_0042);
    busyM = 1'b1;
    add(OP_STAT, `CFG_STATUS, 1, 1, 0, CHK_DOUT, statusWord());
    busyM = 1'b0;
    add(OP_STAT, `CFG_STATUS, 1, 0, 0, CHK_DOUT, statusWord());
    add(OP_DONE, `CFG_ID, 1, 0, 0, CHK_NONE, '0);
    pending = 1'b1;
    add(OP_HREAD, `CFG_STATUS, 1, 0, 0, CHK_INT, 0);
    add(OP_HREAD, `CFG_STATUS, 1, 0, 0, CHK_DOUT, statusWord());
    hostWrite(`CFG_STATUS, 1, 32'h0001_0000);
    add(OP_IDLE, `CFG_ID, 1, 0, 0, CHK_INT, 1);
    add(OP_DONE, `CFG_ID, 1, 0, 0, CHK_INT, 1);
    add(OP_IDLE, `CFG_ID, 1, 0, 0, CHK_INT, 1);
    hostWrite(`CFG_STATUS, 1, 32'h0001_0100);
    add(OP_IDLE, `CFG_ID, 1, 0, 0, CHK_INT, 0);
    add(OP_HREAD, `CFG_STATUS, 1, 0, 0, CHK_DOUT, statusWord());
    add(OP_START, `CFG_ID, 1, 1, 0, CHK_START, 1);
    add(OP_START, `CFG_ID, 1, 0, 0, CHK_START, 0);
  endtask

  initial begin
    {en, writeAip, readAip, startAip, wrEnMemOut, busy, doneIrq} = '0;
    {configAip, dataIn, wrDataMemOut, expVal, rdAddr0, rdAddr1, wrAddrMemOut} = '0;
    chkSel = CHK_NONE;
    testId = 0;
    buildTable();
    built = 1'b1;
    wait (rst === 1'b1);
    foreach (tbl[i]) begin
      @(posedge clk);
      #1;
      e = tbl[i];
      configAip = e.code;
      en = e.en;
      dataIn = e.data;
      writeAip = (e.op == OP_HWRITE);
      readAip = (e.op == OP_HREAD);
      wrEnMemOut = (e.op == OP_CWRITE);
      wrDataMemOut = e.data;
      wrAddrMemOut = memOutAddr_t'(e.addr);
      rdAddr0 = memInAddr_t'(e.addr);
      rdAddr1 = memInAddr_t'(e.addr);
      if (e.op == OP_STAT) busy = e.data[0];
      doneIrq = (e.op == OP_DONE);
      if (e.op == OP_START) startAip = e.data[0];
      chkSel = e.chk;
      expVal = e.exp;
      testId = i;
    end
    @(posedge clk);
    #1;
    {writeAip, readAip, wrEnMemOut, doneIrq} = '0;
    chkSel = CHK_NONE;
    @(posedge clk);
    #1;
    $display("Checks run %0d, failed %0d", checkCount, errCount);
    if (errCount == 0 && checkCount > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (built);
    #((tbl.size() + 20) * 8);
    $display("Timeout: the stimulus loop did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
hdl/aipPkg.sv
hdl/aipBankRam.sv
hdl/aipCmdDecode.sv
hdl/aipExecute.sv
hdl/aipResult.sv
hdl/aipTop.sv
verification/tbClock.sv
verification/aipChecker.sv
verification/aipTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= aipTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
